//--- include/pad_consts.svh
/*
 * Pad multiplexer constants
 * pad count, select width, register layout, clock divider, ID word
 */
`ifndef PAD_CONSTS_SVH
`define PAD_CONSTS_SVH

// 18 vertical and 4 horizontal muxed pads
`define PAD_NUM_MUXED 22
`define PAD_SEL_W 2
`define PADS_PER_WORD 16

// register bus
`define REG_ADDR_W 4
`define REG_DATA_W 32

`define SLINK_LANES 8

// ref clock to rt clock ratio
`define RT_CLK_DIV 100

`define PAD_ID_WORD 32'hCACABABE

`endif

//--- design/pad_pkg.sv
/*
 * Pad function select encoding
 * select register word with raw and per-pad views
 */
`include "pad_consts.svh"

package pad_pkg;

  // reserved value behaves like input only
  typedef enum logic [`PAD_SEL_W-1:0] {
    PAD_SEL_INPUT = 2'd0,
    PAD_SEL_GPIO  = 2'd1,
    PAD_SEL_SLINK = 2'd2,
    PAD_SEL_RSVD  = 2'd3
  } pad_sel_e;

  // bus writes the raw word, the mux reads the select fields
  typedef union packed {
    logic [`REG_DATA_W-1:0]        raw;
    pad_sel_e [`PADS_PER_WORD-1:0] sel;
  } pad_cfg_word_u;

endpackage

//--- design/reg_pkg.sv
/*
 * Register bus types
 * word address, data word, response
 */
`include "pad_consts.svh"

package reg_pkg;

  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`REG_DATA_W-1:0] reg_data_t;

  typedef struct packed {
    reg_data_t rdata;
    logic      error;
  } reg_rsp_t;

endpackage

//--- design/cfg_bus_if.sv
/*
 * Register bus with valid/ready request and response channels
 */
interface cfg_bus_if;

  // request channel
  logic               req_valid;
  logic               req_ready;
  logic               req_write;
  reg_pkg::reg_addr_t req_addr;
  reg_pkg::reg_data_t req_wdata;

  // response channel
  logic               rsp_valid;
  logic               rsp_ready;
  reg_pkg::reg_rsp_t  rsp;

  modport host (
    output req_valid, req_write, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp
  );

  modport device (
    input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp
  );

endinterface

//--- design/clk_rst_gen.sv
/*
 * Power-on reset synchronizer on the reference clock
 * static divider for the real-time clock
 */
`include "pad_consts.svh"

module clk_rst_gen (
  input  logic ref_clk_i,
  input  logic arst_n_i,
  output logic rst_n_o,
  output logic rt_clk_o
);

  localparam int unsigned half_div = `RT_CLK_DIV / 2;
  localparam int unsigned cnt_w    = $clog2(half_div);

  logic [1:0]       sync_q;
  logic [cnt_w-1:0] cnt_q;
  logic             rt_clk_q;

  // async assert, release after two edges
  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = sync_q[1];

  ////////////////////
  // rt clock divider
  ////////////////////

  always_ff @(posedge ref_clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      cnt_q    <= '0;
      rt_clk_q <= 1'b0;
    end else if (cnt_q == cnt_w'(half_div - 1)) begin
      cnt_q    <= '0;
      rt_clk_q <= ~rt_clk_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rt_clk_o = rt_clk_q;

  a_cnt_range: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
    cnt_q <= cnt_w'(half_div - 1))
    else $error("divider counter past its terminal value");

endmodule

//--- design/pad_cfg_regs.sv
/*
 * Pad select register file and identification word
 * one access in flight, response one cycle after acceptance
 */
`include "pad_consts.svh"

module pad_cfg_regs (
  input  logic                                   ref_clk_i,
  input  logic                                   rst_n_i,
  cfg_bus_if.device                              bus,
  output pad_pkg::pad_sel_e [`PAD_NUM_MUXED-1:0] pad_sel_o
);

  localparam int unsigned num_cfg_regs =
    (`PAD_NUM_MUXED + `PADS_PER_WORD - 1) / `PADS_PER_WORD;
  localparam int unsigned idx_w = $clog2(num_cfg_regs);
  // id word sits right after the select registers
  localparam reg_pkg::reg_addr_t id_addr = reg_pkg::reg_addr_t'(num_cfg_regs);

  // bits of register r that hold real pad selects
  function automatic reg_pkg::reg_data_t used_mask(int unsigned r);
    int unsigned pads;
    pads = `PAD_NUM_MUXED - r * `PADS_PER_WORD;
    if (pads >= `PADS_PER_WORD) return '1;
    return reg_pkg::reg_data_t'((64'd1 << (pads * `PAD_SEL_W)) - 64'd1);
  endfunction

  pad_pkg::pad_cfg_word_u  cfg_q [num_cfg_regs];
  logic [num_cfg_regs-1:0] wr_en;
  logic [idx_w-1:0]        idx;
  logic                    req_fire;
  logic                    rsp_valid_q;
  reg_pkg::reg_rsp_t       rsp_d;
  reg_pkg::reg_rsp_t       rsp_q;

  assign req_fire = bus.req_valid & bus.req_ready;
  assign idx      = bus.req_addr[idx_w-1:0];

  ////////////////////
  // request decode
  ////////////////////

  always_comb begin
    wr_en = '0;
    rsp_d = '0;
    if (bus.req_addr < id_addr) begin
      if (bus.req_write) begin
        wr_en[idx] = req_fire;
      end else begin
        rsp_d.rdata = cfg_q[idx].raw;
      end
    end else if (bus.req_addr == id_addr && !bus.req_write) begin
      rsp_d.rdata = `PAD_ID_WORD;
    end else begin
      // id write or unmapped address
      rsp_d.error = 1'b1;
    end
  end

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '{default: '0};
    end else begin
      for (int r = 0; r < num_cfg_regs; r++) begin
        if (wr_en[r]) cfg_q[r].raw <= bus.req_wdata & used_mask(r);
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (req_fire) rsp_q <= rsp_d;
  end

  // ready stays low while the internal reset is held
  assign bus.req_ready = rst_n_i & (~rsp_valid_q | bus.rsp_ready);
  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp       = rsp_q;

  for (genvar p = 0; p < `PAD_NUM_MUXED; p++) begin : gen_sel
    assign pad_sel_o[p] = cfg_q[p / `PADS_PER_WORD].sel[p % `PADS_PER_WORD];
  end

  a_rsp_hold: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    bus.rsp_valid && !bus.rsp_ready |=> bus.rsp_valid && $stable(bus.rsp))
    else $error("response dropped or changed under back-pressure");

  a_no_accept: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    bus.rsp_valid && !bus.rsp_ready |-> !bus.req_ready)
    else $error("request accepted while a response is pending");

  a_last_reg: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    (cfg_q[num_cfg_regs-1].raw & ~used_mask(num_cfg_regs - 1)) == '0)
    else $error("select stored outside the last register's fields");

endmodule

//--- design/pad_mux.sv
/*
 * Per-pad function steering
 * gpio and serial-link outputs, gpio inputs
 */
`include "pad_consts.svh"

module pad_mux (
  input  pad_pkg::pad_sel_e [`PAD_NUM_MUXED-1:0] pad_sel_i,
  input  logic [`PAD_NUM_MUXED-1:0]              soc_gpio_out_i,
  input  logic [`PAD_NUM_MUXED-1:0]              soc_gpio_oe_i,
  input  logic [`SLINK_LANES-1:0]                soc_slink_out_i,
  input  logic [`PAD_NUM_MUXED-1:0]              pad_in_i,
  output logic [`PAD_NUM_MUXED-1:0]              pad_out_o,
  output logic [`PAD_NUM_MUXED-1:0]              pad_oe_o,
  output logic [`PAD_NUM_MUXED-1:0]              soc_gpio_in_o
);

  for (genvar n = 0; n < `PAD_NUM_MUXED; n++) begin : gen_pad
    // lanes wrap around the pad ring
    localparam int unsigned lane = n % `SLINK_LANES;

    always_comb begin
      pad_out_o[n]     = 1'b0;
      pad_oe_o[n]      = 1'b0;
      soc_gpio_in_o[n] = 1'b0;
      case (pad_sel_i[n])
        pad_pkg::PAD_SEL_GPIO: begin
          pad_out_o[n]     = soc_gpio_out_i[n];
          pad_oe_o[n]      = soc_gpio_oe_i[n];
          soc_gpio_in_o[n] = pad_in_i[n];
        end
        pad_pkg::PAD_SEL_SLINK: begin
          pad_out_o[n] = soc_slink_out_i[lane];
          pad_oe_o[n]  = 1'b1;
        end
        // output stays off
        pad_pkg::PAD_SEL_INPUT, pad_pkg::PAD_SEL_RSVD: begin
          pad_oe_o[n] = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- design/astral_pad_top.sv
/*
 * Pad multiplexing top level
 * reset and rt clock, select registers, pad mux
 */
`include "pad_consts.svh"

module astral_pad_top (
  input  logic                      ref_clk_i,
  input  logic                      arst_n_i,
  // register bus
  input  logic                      cfg_req_valid_i,
  output logic                      cfg_req_ready_o,
  input  logic                      cfg_req_write_i,
  input  logic [`REG_ADDR_W-1:0]    cfg_req_addr_i,
  input  logic [`REG_DATA_W-1:0]    cfg_req_wdata_i,
  output logic                      cfg_rsp_valid_o,
  input  logic                      cfg_rsp_ready_i,
  output logic [`REG_DATA_W-1:0]    cfg_rsp_rdata_o,
  output logic                      cfg_rsp_error_o,
  // soc side
  input  logic [`PAD_NUM_MUXED-1:0] soc_gpio_out_i,
  input  logic [`PAD_NUM_MUXED-1:0] soc_gpio_oe_i,
  output logic [`PAD_NUM_MUXED-1:0] soc_gpio_in_o,
  input  logic [`SLINK_LANES-1:0]   soc_slink_out_i,
  // pad side
  input  logic [`PAD_NUM_MUXED-1:0] pad_in_i,
  output logic [`PAD_NUM_MUXED-1:0] pad_out_o,
  output logic [`PAD_NUM_MUXED-1:0] pad_oe_o,
  output logic                      rt_clk_o
);

  logic                                   rst_n;
  pad_pkg::pad_sel_e [`PAD_NUM_MUXED-1:0] pad_sel;

  ////////////////////
  // clock and reset
  ////////////////////

  clk_rst_gen i_clk_rst_gen (
    .ref_clk_i ( ref_clk_i ),
    .arst_n_i  ( arst_n_i  ),
    .rst_n_o   ( rst_n     ),
    .rt_clk_o  ( rt_clk_o  )
  );

  ////////////////////
  // config registers
  ////////////////////

  cfg_bus_if i_cfg_bus ();

  assign i_cfg_bus.req_valid = cfg_req_valid_i;
  assign i_cfg_bus.req_write = cfg_req_write_i;
  assign i_cfg_bus.req_addr  = cfg_req_addr_i;
  assign i_cfg_bus.req_wdata = cfg_req_wdata_i;
  assign i_cfg_bus.rsp_ready = cfg_rsp_ready_i;
  assign cfg_req_ready_o     = i_cfg_bus.req_ready;
  assign cfg_rsp_valid_o     = i_cfg_bus.rsp_valid;
  assign cfg_rsp_rdata_o     = i_cfg_bus.rsp.rdata;
  assign cfg_rsp_error_o     = i_cfg_bus.rsp.error;

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( rst_n     ),
    .bus       ( i_cfg_bus ),
    .pad_sel_o ( pad_sel   )
  );

  pad_mux i_pad_mux (
    .pad_sel_i       ( pad_sel         ),
    .soc_gpio_out_i  ( soc_gpio_out_i  ),
    .soc_gpio_oe_i   ( soc_gpio_oe_i   ),
    .soc_slink_out_i ( soc_slink_out_i ),
    .pad_in_i        ( pad_in_i        ),
    .pad_out_o       ( pad_out_o       ),
    .pad_oe_o        ( pad_oe_o        ),
    .soc_gpio_in_o   ( soc_gpio_in_o   )
  );

endmodule

//--- bench/pad_checker.sv
/*
 * Pad multiplexing checker
 * register model, reference pad function, response and rt clock checks
 */
`include "pad_consts.svh"

module pad_checker (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         req_valid_i,
  input  logic                         req_ready_i,
  input  logic                         req_write_i,
  input  logic [`REG_ADDR_W-1:0]       req_addr_i,
  input  logic [`REG_DATA_W-1:0]       req_wdata_i,
  input  logic                         rsp_valid_i,
  input  logic                         rsp_ready_i,
  // {rdata, error}
  input  logic [`REG_DATA_W:0]         rsp_i,
  // {gpio_out, gpio_oe, pad_in}
  input  logic [3*`PAD_NUM_MUXED-1:0]  gio_i,
  input  logic [`SLINK_LANES-1:0]      slink_i,
  // {pad_out, pad_oe, gpio_in}
  input  logic [3*`PAD_NUM_MUXED-1:0]  pads_i,
  input  logic                         rt_clk_i,
  output int unsigned                  err_cnt_o,
  output int unsigned                  phase_cnt_o
);

  localparam logic [`REG_DATA_W-1:0] reg1_mask =
    (1 << (`PAD_SEL_W * (`PAD_NUM_MUXED - `PADS_PER_WORD))) - 1;

  // both select words, pad n at bits 2n+1:2n
  logic [2*`REG_DATA_W-1:0]    model = '0;
  logic [`REG_DATA_W:0]        exp_q [$];
  logic [3*`PAD_NUM_MUXED-1:0] exp_pads;
  logic                        acc_prev = 1'b0;
  logic                        held_prev = 1'b0;
  logic                        rt_prev = 1'b0;
  logic                        rt_edge_seen = 1'b0;
  int unsigned                 rel_cnt = 0;
  int unsigned                 phase_len = 0;
  int unsigned                 errs = 0;
  int unsigned                 phases = 0;

  assign err_cnt_o   = errs;
  assign phase_cnt_o = phases;

  function automatic void report(input string msg);
    $display("%s", msg);
    errs++;
  endfunction

  function automatic logic [3*`PAD_NUM_MUXED-1:0] ref_pads(
      input logic [2*`REG_DATA_W-1:0] m, input logic [3*`PAD_NUM_MUXED-1:0] gio,
      input logic [`SLINK_LANES-1:0] lanes);
    logic [`PAD_NUM_MUXED-1:0] p_out;
    logic [`PAD_NUM_MUXED-1:0] p_oe;
    logic [`PAD_NUM_MUXED-1:0] g_in;
    p_out = '0;
    p_oe  = '0;
    g_in  = '0;
    for (int n = 0; n < `PAD_NUM_MUXED; n++) begin
      // 1 gpio, 2 serial lane, 0 and 3 input only
      if (m[`PAD_SEL_W*n +: `PAD_SEL_W] == 2'd1) begin
        p_out[n] = gio[2*`PAD_NUM_MUXED + n];
        p_oe[n]  = gio[`PAD_NUM_MUXED + n];
        g_in[n]  = gio[n];
      end else if (m[`PAD_SEL_W*n +: `PAD_SEL_W] == 2'd2) begin
        p_out[n] = lanes[n % `SLINK_LANES];
        p_oe[n]  = 1'b1;
      end
    end
    return {p_out, p_oe, g_in};
  endfunction

  function automatic logic [`REG_DATA_W:0] ref_rsp(input logic wr,
      input logic [`REG_ADDR_W-1:0] a, input logic [2*`REG_DATA_W-1:0] m);
    if (a > 2 || (a == 2 && wr)) return {{`REG_DATA_W{1'b0}}, 1'b1};
    if (wr) return '0;
    if (a == 2) return {`PAD_ID_WORD, 1'b0};
    return {(a == 0) ? m[`REG_DATA_W-1:0] : m[2*`REG_DATA_W-1:`REG_DATA_W], 1'b0};
  endfunction

  // mid-cycle sampling, a handshake seen here completes on the next rising edge
  always @(negedge clk_i) begin
    exp_pads = ref_pads(model, gio_i, slink_i);
    if (!arst_n_i) begin
      model = '0;
      exp_q.delete();
      acc_prev     = 1'b0;
      held_prev    = 1'b0;
      rt_edge_seen = 1'b0;
      rel_cnt      = 0;
      if (req_ready_i || rsp_valid_i || rt_clk_i) begin
        report($sformatf("bus handshake or rt clock active during reset at %0t", $time));
      end
    end else begin
      if (pads_i !== exp_pads) begin
        report($sformatf("mismatch at %0t: pads %h, expected %h", $time, pads_i, exp_pads));
      end
      if (rel_cnt < 4) rel_cnt++;
      // internal reset lifts on the second rising edge after arst_n rises
      if (rel_cnt < 3 && (req_ready_i || rsp_valid_i)) begin
        report($sformatf("bus handshake active before reset release at %0t", $time));
      end
      if (rel_cnt == 3) begin
        if (!req_ready_i || rsp_valid_i || pads_i[2*`PAD_NUM_MUXED-1:0] != '0) begin
          report($sformatf("bus or pads not idle after reset release at %0t", $time));
        end
      end
      if (rsp_valid_i) begin
        if (exp_q.size() == 0) begin
          report($sformatf("response without a request at %0t", $time));
        end else begin
          if (rsp_i !== exp_q[0]) begin
            report($sformatf("mismatch at %0t: response %h, expected %h",
                             $time, rsp_i, exp_q[0]));
          end
          if (rsp_ready_i) void'(exp_q.pop_front());
        end
        if (!rsp_ready_i && req_ready_i) begin
          report($sformatf("request ready while a response is held at %0t", $time));
        end
      end else if (acc_prev || held_prev) begin
        report($sformatf("response missing or withdrawn at %0t", $time));
      end
      held_prev = rsp_valid_i && !rsp_ready_i;
      acc_prev  = req_valid_i && req_ready_i;
      if (acc_prev) begin
        exp_q.push_back(ref_rsp(req_write_i, req_addr_i, model));
        if (req_write_i && req_addr_i == 0) model[`REG_DATA_W-1:0] = req_wdata_i;
        if (req_write_i && req_addr_i == 1) begin
          model[2*`REG_DATA_W-1:`REG_DATA_W] = req_wdata_i & reg1_mask;
        end
      end
      phase_len++;
      if (rt_clk_i != rt_prev) begin
        // the first edge only starts the count
        if (rt_edge_seen) begin
          phases++;
          if (phase_len != `RT_CLK_DIV / 2) begin
            report($sformatf("mismatch at %0t: rt clock phase %0d cycles, expected %0d",
                             $time, phase_len, `RT_CLK_DIV / 2));
          end
        end
        rt_edge_seen = 1'b1;
        phase_len    = 0;
      end
    end
    rt_prev = rt_clk_i;
  end

endmodule

//--- bench/tb_astral_pad.sv
/*
 * Pad multiplexing testbench
 * clock, reset, LFSR stimulus, watchdog, DUT and checker
 */
`include "pad_consts.svh"

module tb_astral_pad;

  typedef logic [`REG_ADDR_W-1:0]    addr_t;
  typedef logic [`PAD_NUM_MUXED-1:0] pads_t;
  typedef logic [`SLINK_LANES-1:0]   lanes_t;

  localparam int unsigned clk_period = 10;
  localparam int unsigned rst_cycles = 8;
  localparam int unsigned n_rw       = 24;
  localparam int unsigned n_mux      = 40;
  localparam int unsigned n_bp       = 16;
  localparam int unsigned n_phase    = 4;
  localparam logic [15:0] seed       = 16'd20;
  // about 6 cycles per access, 16 per back-pressured pair
  localparam int unsigned test_cycles = rst_cycles + 8 + (2 * n_rw + 28 + n_mux) * 6
                                      + n_bp * 16 + (n_phase + 1) * `RT_CLK_DIV / 2;
  localparam int unsigned wd_time    = 2 * test_cycles * clk_period;

  logic                      clk;
  logic                      arst_n;
  logic                      req_valid;
  logic                      req_ready;
  logic                      req_write;
  addr_t                     req_addr;
  logic [`REG_DATA_W-1:0]    req_wdata;
  logic                      rsp_valid;
  logic                      rsp_ready;
  logic [`REG_DATA_W-1:0]    rsp_rdata;
  logic                      rsp_error;
  pads_t                     gpio_out;
  pads_t                     gpio_oe;
  pads_t                     gpio_in;
  lanes_t                    slink;
  pads_t                     pad_in;
  pads_t                     pad_out;
  pads_t                     pad_oe;
  logic                      rt_clk;
  logic [15:0]               lfsr;
  int unsigned               err_cnt;
  int unsigned               phase_cnt;
  int unsigned               err_base;
  int unsigned               tests_run;

  always #(clk_period / 2) clk = ~clk;

  astral_pad_top i_dut (
    .ref_clk_i       ( clk       ),
    .arst_n_i        ( arst_n    ),
    .cfg_req_valid_i ( req_valid ),
    .cfg_req_ready_o ( req_ready ),
    .cfg_req_write_i ( req_write ),
    .cfg_req_addr_i  ( req_addr  ),
    .cfg_req_wdata_i ( req_wdata ),
    .cfg_rsp_valid_o ( rsp_valid ),
    .cfg_rsp_ready_i ( rsp_ready ),
    .cfg_rsp_rdata_o ( rsp_rdata ),
    .cfg_rsp_error_o ( rsp_error ),
    .soc_gpio_out_i  ( gpio_out  ),
    .soc_gpio_oe_i   ( gpio_oe   ),
    .soc_gpio_in_o   ( gpio_in   ),
    .soc_slink_out_i ( slink     ),
    .pad_in_i        ( pad_in    ),
    .pad_out_o       ( pad_out   ),
    .pad_oe_o        ( pad_oe    ),
    .rt_clk_o        ( rt_clk    )
  );

  pad_checker i_checker (
    .clk_i       ( clk                         ),
    .arst_n_i    ( arst_n                      ),
    .req_valid_i ( req_valid                   ),
    .req_ready_i ( req_ready                   ),
    .req_write_i ( req_write                   ),
    .req_addr_i  ( req_addr                    ),
    .req_wdata_i ( req_wdata                   ),
    .rsp_valid_i ( rsp_valid                   ),
    .rsp_ready_i ( rsp_ready                   ),
    .rsp_i       ( {rsp_rdata, rsp_error}      ),
    .gio_i       ( {gpio_out, gpio_oe, pad_in} ),
    .slink_i     ( slink                       ),
    .pads_i      ( {pad_out, pad_oe, gpio_in}  ),
    .rt_clk_i    ( rt_clk                      ),
    .err_cnt_o   ( err_cnt                     ),
    .phase_cnt_o ( phase_cnt                   )
  );

  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic start_req(input logic wr, input addr_t addr, input logic [`REG_DATA_W-1:0] data);
    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= wr;
    req_addr  <= addr;
    req_wdata <= data;
  endtask

  // ready is looked at mid-cycle, the transfer is on the next rising edge
  task automatic wait_accept();
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_rsp();
    @(negedge clk);
    while (!(rsp_valid && rsp_ready)) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic access(input logic wr, input addr_t addr, input logic [`REG_DATA_W-1:0] data);
    start_req(wr, addr, data);
    wait_accept();
    wait_rsp();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  initial begin
    addr_t       a;
    int unsigned p0;
    clk       = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    rsp_ready = 1'b1;
    gpio_out  = '0;
    gpio_oe   = '0;
    slink     = '0;
    pad_in    = '0;
    lfsr      = seed;
    err_base  = 0;
    tests_run = 0;
    repeat (rst_cycles) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    end_test("reset state");

    for (int unsigned i = 0; i < n_rw; i++) begin
      a = addr_t'(lfsr_bits(1));
      access(1'b1, a, lfsr_bits(32));
      access(1'b0, a, '0);
    end
    end_test("select write and read back");

    access(1'b0, addr_t'(2), '0);
    access(1'b1, addr_t'(2), lfsr_bits(32));
    for (int unsigned a3 = 3; a3 < (1 << `REG_ADDR_W); a3++) begin
      access(1'b0, addr_t'(a3), '0);
      access(1'b1, addr_t'(a3), lfsr_bits(32));
    end
    end_test("id word and unmapped addresses");

    for (int unsigned i = 0; i < n_mux; i++) begin
      @(posedge clk);
      gpio_out <= pads_t'(lfsr_bits(`PAD_NUM_MUXED));
      gpio_oe  <= pads_t'(lfsr_bits(`PAD_NUM_MUXED));
      pad_in   <= pads_t'(lfsr_bits(`PAD_NUM_MUXED));
      slink    <= lanes_t'(lfsr_bits(`SLINK_LANES));
      access(1'b1, addr_t'(lfsr_bits(1)), lfsr_bits(32));
    end
    end_test("pad steering");

    // second request waits behind a stalled response
    for (int unsigned i = 0; i < n_bp; i++) begin
      rsp_ready <= 1'b0;
      start_req(1'b1, addr_t'(lfsr_bits(1)), lfsr_bits(32));
      wait_accept();
      start_req(1'b0, addr_t'(lfsr_bits(2)), '0);
      repeat (1 + lfsr_bits(3)) @(posedge clk);
      rsp_ready <= 1'b1;
      wait_accept();
      wait_rsp();
    end
    end_test("response back-pressure");

    p0 = phase_cnt;
    while (phase_cnt < p0 + n_phase) @(posedge clk);
    end_test("rt clock phases");

    $display("%0d tests, %0d rt clock phases checked, %0d errors", tests_run, phase_cnt,
             err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(wd_time);
    $display("timeout in test %0d, a handshake or rt clock edge never came", tests_run + 1);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
design/pad_pkg.sv
design/reg_pkg.sv
design/cfg_bus_if.sv
design/clk_rst_gen.sv
design/pad_cfg_regs.sv
design/pad_mux.sv
design/astral_pad_top.sv
bench/pad_checker.sv
bench/tb_astral_pad.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_astral_pad
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
